//--- fifo_shared_pkg.sv
package fifo_shared_pkg;

  localparam int fifo_id_w = 2;
  localparam int addr_w = 4;
  localparam int data_w = 16;
  // Wide enough to hold a full count of 2^addr_w credits
  localparam int count_w = addr_w + 1;

  typedef struct packed {
    logic [fifo_id_w-1:0] fifo_id;
    logic [data_w-1:0]    data;
  } push_req_t;

  // New tail entry for one logical FIFO
  typedef struct packed {
    logic                 valid;
    logic [fifo_id_w-1:0] fifo_id;
    logic [addr_w-1:0]    entry;
  } tail_upd_t;

  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] entry;
  } dealloc_t;

  typedef struct packed {
    logic                 valid;
    logic [fifo_id_w-1:0] fifo_id;
    logic [data_w-1:0]    data;
  } pop_resp_t;

  typedef enum logic {
    fl_init,
    fl_run
  } fl_state_t;

endpackage

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int depth = 16
) (
  input  logic                               clk,
  input  logic                               wr_en,
  input  logic [fifo_shared_pkg::addr_w-1:0] wr_addr,
  input  logic [fifo_shared_pkg::data_w-1:0] wr_data,
  input  logic                               rd_en,
  input  logic [fifo_shared_pkg::addr_w-1:0] rd_addr,
  output logic [fifo_shared_pkg::data_w-1:0] rd_data
);
  import fifo_shared_pkg::*;

  logic [data_w-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle of latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- credit_receiver.sv
`timescale 1ns/1ps

module credit_receiver #(
  parameter int depth = 16
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  push_sender_in_reset,
  output logic                                  push_receiver_in_reset,
  input  logic                                  push_credit_stall,
  output logic                                  push_credit,
  input  logic                                  push_valid,
  input  fifo_shared_pkg::push_req_t            push_req,
  input  fifo_shared_pkg::dealloc_t             dealloc,
  input  logic [fifo_shared_pkg::count_w-1:0]   credit_initial,
  input  logic [fifo_shared_pkg::count_w-1:0]   credit_withhold,
  output logic [fifo_shared_pkg::count_w-1:0]   credit_available,
  output logic [fifo_shared_pkg::count_w-1:0]   credit_count,
  output logic                                  int_valid,
  output fifo_shared_pkg::push_req_t            int_req
);
  import fifo_shared_pkg::*;

  localparam logic [count_w-1:0] max_credit = count_w'(depth);

  logic               either_rst;
  logic               above_withhold;
  logic [count_w-1:0] init_load;
  logic [count_w-1:0] count_next;

  // Sender reset counts as reset for the whole push path
  assign either_rst = !rst_n || push_sender_in_reset;
  assign push_receiver_in_reset = !rst_n;

  // Never hand out more credits than the RAM has entries
  assign init_load = (credit_initial > max_credit) ? max_credit : credit_initial;

  assign above_withhold = credit_count > credit_withhold;

  // At most one credit goes back per cycle
  assign push_credit = !either_rst && !push_credit_stall && above_withhold;

  assign credit_available = above_withhold ? credit_count - credit_withhold : '0;

  // Returned entries and released credits land in one update
  assign count_next = credit_count + count_w'(dealloc.valid) - count_w'(push_credit);

  always_ff @(posedge clk) begin
    if (either_rst) begin
      credit_count <= init_load;
      int_valid <= 1'b0;
    end else begin
      credit_count <= count_next;
      int_valid <= push_valid;
    end
  end

  // Push payload registered for the freelist
  always_ff @(posedge clk) begin
    if (push_valid) begin
      int_req <= push_req;
    end
  end

endmodule

//--- freelist_alloc.sv
`timescale 1ns/1ps

module freelist_alloc #(
  parameter int depth = 16
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 int_valid,
  input  fifo_shared_pkg::push_req_t           int_req,
  input  fifo_shared_pkg::dealloc_t            dealloc_in,
  output logic                                 push_full,
  output logic                                 wr_en,
  output logic [fifo_shared_pkg::addr_w-1:0]   wr_addr,
  output logic [fifo_shared_pkg::data_w-1:0]   wr_data,
  output fifo_shared_pkg::tail_upd_t           tail_upd,
  output fifo_shared_pkg::dealloc_t            dealloc_out
);
  import fifo_shared_pkg::*;

  // Entry 0 goes straight to staging, the rest start in the pool
  localparam logic [depth-1:0] init_pool = ~(depth'(1));

  fl_state_t         state;
  logic [depth-1:0]  pool;
  logic [depth-1:0]  pool_next;
  logic [addr_w-1:0] stage_entry;
  logic              stage_valid;
  logic [addr_w-1:0] pick_entry;
  logic              pick_valid;
  logic              alloc;
  logic              refill;

  // Lowest free index wins
  always_comb begin
    pick_valid = 1'b0;
    pick_entry = '0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (pool[i]) begin
        pick_valid = 1'b1;
        pick_entry = addr_w'(i);
      end
    end
  end

  assign alloc = int_valid && stage_valid;
  assign refill = (state == fl_run) && pick_valid && (!stage_valid || alloc);

  always_comb begin
    pool_next = pool;
    if (refill) begin
      pool_next[pick_entry] = 1'b0;
    end
    if (dealloc_in.valid) begin
      pool_next[dealloc_in.entry] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= fl_init;
      pool <= '0;
      stage_entry <= '0;
      stage_valid <= 1'b0;
    end else begin
      case (state)
        fl_init: begin
          pool <= init_pool;
          stage_entry <= '0;
          stage_valid <= 1'b1;
          state <= fl_run;
        end
        default: begin
          pool <= pool_next;
          if (refill) begin
            stage_entry <= pick_entry;
            stage_valid <= 1'b1;
          end else if (alloc) begin
            stage_valid <= 1'b0;
          end
        end
      endcase
    end
  end

  // No staged entry in run means every entry is in use
  assign push_full = (state == fl_run) && !stage_valid;

  assign wr_en = alloc;
  assign wr_addr = stage_entry;
  assign wr_data = int_req.data;

  assign tail_upd.valid = alloc;
  assign tail_upd.fifo_id = int_req.fifo_id;
  assign tail_upd.entry = stage_entry;

  // Each freed entry becomes one credit
  assign dealloc_out = dealloc_in;

endmodule

//--- shared_fifo_push_ctrl_credit.sv
`timescale 1ns/1ps

module shared_fifo_push_ctrl_credit #(
  parameter int num_fifos = 4,
  parameter int depth = 16
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 push_sender_in_reset,
  output logic                                 push_receiver_in_reset,
  input  logic                                 push_credit_stall,
  output logic                                 push_credit,
  input  logic                                 push_valid,
  input  fifo_shared_pkg::push_req_t           push_req,
  output logic                                 push_full,
  input  logic [fifo_shared_pkg::count_w-1:0]  credit_initial,
  input  logic [fifo_shared_pkg::count_w-1:0]  credit_withhold,
  output logic [fifo_shared_pkg::count_w-1:0]  credit_available,
  output logic [fifo_shared_pkg::count_w-1:0]  credit_count,
  input  fifo_shared_pkg::dealloc_t            dealloc,
  output logic                                 wr_en,
  output logic [fifo_shared_pkg::addr_w-1:0]   wr_addr,
  output logic [fifo_shared_pkg::data_w-1:0]   wr_data,
  output fifo_shared_pkg::tail_upd_t           tail_upd
);
  import fifo_shared_pkg::*;

  logic      push_rst_n;
  logic      rst_dly;
  logic      stall_int;
  logic      int_valid;
  push_req_t int_req;
  push_req_t fl_req;
  dealloc_t  credit_dealloc;

  assign push_rst_n = rst_n && !push_sender_in_reset;

  // The staging entry is only there one cycle after reset, so hold credits back that long
  always_ff @(posedge clk) begin
    if (!push_rst_n) begin
      rst_dly <= 1'b1;
    end else begin
      rst_dly <= 1'b0;
    end
  end

  assign stall_int = push_credit_stall || rst_dly;

  credit_receiver #(
    .depth(depth)
  ) u_credit_receiver (
    .clk,
    .rst_n,
    .push_sender_in_reset,
    .push_receiver_in_reset,
    .push_credit_stall(stall_int),
    .push_credit,
    .push_valid,
    .push_req,
    .dealloc(credit_dealloc),
    .credit_initial,
    .credit_withhold,
    .credit_available,
    .credit_count,
    .int_valid,
    .int_req
  );

  // Ids past the last FIFO fold into it
  always_comb begin
    fl_req = int_req;
    if (int_req.fifo_id > fifo_id_w'(num_fifos - 1)) begin
      fl_req.fifo_id = fifo_id_w'(num_fifos - 1);
    end
  end

  freelist_alloc #(
    .depth(depth)
  ) u_freelist_alloc (
    .clk,
    .rst_n(push_rst_n),
    .int_valid,
    .int_req(fl_req),
    .dealloc_in(dealloc),
    .push_full,
    .wr_en,
    .wr_addr,
    .wr_data,
    .tail_upd,
    .dealloc_out(credit_dealloc)
  );

endmodule

//--- linked_list_ctrl.sv
`timescale 1ns/1ps

module linked_list_ctrl #(
  parameter int num_fifos = 4,
  parameter int depth = 16
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  fifo_shared_pkg::tail_upd_t                          tail_upd,
  input  logic                                                pop_take,
  input  logic [fifo_shared_pkg::fifo_id_w-1:0]               pop_take_id,
  output logic [num_fifos-1:0][fifo_shared_pkg::addr_w-1:0]   head,
  output logic [num_fifos-1:0]                                fifo_empty
);
  import fifo_shared_pkg::*;

  logic [num_fifos-1:0][addr_w-1:0] tail;
  logic [addr_w-1:0]                next_ptr [depth];
  logic [num_fifos-1:0]             push_hit;
  logic [num_fifos-1:0]             take_hit;
  logic [num_fifos-1:0]             last_one;
  logic                             link_en;
  logic [addr_w-1:0]                link_addr;

  for (genvar f = 0; f < num_fifos; f++) begin : gen_hit
    assign push_hit[f] = tail_upd.valid && (tail_upd.fifo_id == fifo_id_w'(f));
    assign take_hit[f] = pop_take && (pop_take_id == fifo_id_w'(f));
    // Head meets tail on a single-element list
    assign last_one[f] = head[f] == tail[f];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      fifo_empty <= '1;
    end else begin
      for (int f = 0; f < num_fifos; f++) begin
        if (push_hit[f]) begin
          tail[f] <= tail_upd.entry;
        end
        // A push into an empty list, or one that is emptying now, starts a new head
        if (push_hit[f] && (fifo_empty[f] || (take_hit[f] && last_one[f]))) begin
          head[f] <= tail_upd.entry;
          fifo_empty[f] <= 1'b0;
        end else if (take_hit[f]) begin
          if (last_one[f]) begin
            fifo_empty[f] <= 1'b1;
          end else begin
            head[f] <= next_ptr[head[f]];
          end
        end
      end
    end
  end

  // Old tail points at the new entry
  always_comb begin
    link_en = 1'b0;
    link_addr = '0;
    for (int f = 0; f < num_fifos; f++) begin
      if (push_hit[f] && !fifo_empty[f]) begin
        link_en = 1'b1;
        link_addr = tail[f];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (link_en) begin
      next_ptr[link_addr] <= tail_upd.entry;
    end
  end

endmodule

//--- pop_ctrl.sv
`timescale 1ns/1ps

module pop_ctrl #(
  parameter int num_fifos = 4
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                pop,
  input  logic [fifo_shared_pkg::fifo_id_w-1:0]               pop_fifo_id,
  input  logic [num_fifos-1:0][fifo_shared_pkg::addr_w-1:0]   head,
  input  logic [num_fifos-1:0]                                fifo_empty,
  input  logic [fifo_shared_pkg::data_w-1:0]                  rd_data,
  output logic                                                pop_take,
  output logic [fifo_shared_pkg::fifo_id_w-1:0]               pop_take_id,
  output logic                                                rd_en,
  output logic [fifo_shared_pkg::addr_w-1:0]                  rd_addr,
  output fifo_shared_pkg::pop_resp_t                          pop_resp,
  output fifo_shared_pkg::dealloc_t                           dealloc
);
  import fifo_shared_pkg::*;

  logic                 id_ok;
  logic [fifo_id_w-1:0] safe_id;
  logic                 resp_valid;
  logic [fifo_id_w-1:0] resp_id;
  logic [addr_w-1:0]    resp_entry;

  // Ids with no FIFO behind them are treated like an empty FIFO
  assign id_ok = pop_fifo_id <= fifo_id_w'(num_fifos - 1);
  assign safe_id = id_ok ? pop_fifo_id : '0;

  assign pop_take = pop && id_ok && !fifo_empty[safe_id];
  assign pop_take_id = safe_id;

  // Head entry goes to the RAM in the cycle of the pop
  assign rd_en = pop_take;
  assign rd_addr = head[safe_id];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= pop_take;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_take) begin
      resp_id <= safe_id;
      resp_entry <= head[safe_id];
    end
  end

  // Data is back from the RAM one cycle later
  assign pop_resp.valid = resp_valid;
  assign pop_resp.fifo_id = resp_id;
  assign pop_resp.data = rd_data;

  // Entry is free as soon as its data has been read
  assign dealloc.valid = resp_valid;
  assign dealloc.entry = resp_entry;

endmodule

//--- shared_fifo_top.sv
`timescale 1ns/1ps

module shared_fifo_top #(
  parameter int num_fifos = 4,
  parameter int depth = 16
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 push_sender_in_reset,
  output logic                                 push_receiver_in_reset,
  input  logic                                 push_credit_stall,
  output logic                                 push_credit,
  input  logic                                 push_valid,
  input  fifo_shared_pkg::push_req_t           push_req,
  output logic                                 push_full,
  input  logic [fifo_shared_pkg::count_w-1:0]  credit_initial,
  input  logic [fifo_shared_pkg::count_w-1:0]  credit_withhold,
  output logic [fifo_shared_pkg::count_w-1:0]  credit_available,
  output logic [fifo_shared_pkg::count_w-1:0]  credit_count,
  input  logic                                 pop,
  input  logic [fifo_shared_pkg::fifo_id_w-1:0] pop_fifo_id,
  output fifo_shared_pkg::pop_resp_t           pop_resp,
  output logic [num_fifos-1:0]                 fifo_empty
);
  import fifo_shared_pkg::*;

  logic                             wr_en;
  logic [addr_w-1:0]                wr_addr;
  logic [data_w-1:0]                wr_data;
  tail_upd_t                        tail_upd;
  dealloc_t                         dealloc;
  logic [num_fifos-1:0][addr_w-1:0] head;
  logic                             pop_take;
  logic [fifo_id_w-1:0]             pop_take_id;
  logic                             rd_en;
  logic [addr_w-1:0]                rd_addr;
  logic [data_w-1:0]                rd_data;

  shared_fifo_push_ctrl_credit #(
    .num_fifos(num_fifos),
    .depth(depth)
  ) u_push_ctrl (
    .clk,
    .rst_n,
    .push_sender_in_reset,
    .push_receiver_in_reset,
    .push_credit_stall,
    .push_credit,
    .push_valid,
    .push_req,
    .push_full,
    .credit_initial,
    .credit_withhold,
    .credit_available,
    .credit_count,
    .dealloc,
    .wr_en,
    .wr_addr,
    .wr_data,
    .tail_upd
  );

  linked_list_ctrl #(
    .num_fifos(num_fifos),
    .depth(depth)
  ) u_linked_list (
    .clk,
    .rst_n,
    .tail_upd,
    .pop_take,
    .pop_take_id,
    .head,
    .fifo_empty
  );

  pop_ctrl #(
    .num_fifos(num_fifos)
  ) u_pop_ctrl (
    .clk,
    .rst_n,
    .pop,
    .pop_fifo_id,
    .head,
    .fifo_empty,
    .rd_data,
    .pop_take,
    .pop_take_id,
    .rd_en,
    .rd_addr,
    .pop_resp,
    .dealloc
  );

  data_ram #(
    .depth(depth)
  ) u_data_ram (
    .clk,
    .wr_en,
    .wr_addr,
    .wr_data,
    .rd_en,
    .rd_addr,
    .rd_data
  );

endmodule

//--- tb_shared_fifo.sv
`timescale 1ns/1ps

module tb_shared_fifo;
  import fifo_shared_pkg::*;

  localparam int num_fifos = 4;
  localparam int depth = 16;
  localparam int n_traffic = 400;
  // Resets, credit phases, traffic, two drains with idle tails, full fill
  localparam int test_cycles = 2 * 12 + 30 + 60 + n_traffic + 2 * (100 + 20) + 20;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 push_sender_in_reset;
  logic                 push_receiver_in_reset;
  logic                 push_credit_stall;
  logic                 push_credit;
  logic                 push_valid;
  push_req_t            push_req;
  logic                 push_full;
  logic [count_w-1:0]   credit_initial;
  logic [count_w-1:0]   credit_withhold;
  logic [count_w-1:0]   credit_available;
  logic [count_w-1:0]   credit_count;
  logic                 pop;
  logic [fifo_id_w-1:0] pop_fifo_id;
  pop_resp_t            pop_resp;
  logic [num_fifos-1:0] fifo_empty;

  // Reference model state
  logic [data_w-1:0]  q [num_fifos][$];
  int                 vis_cnt [num_fifos];
  int                 pend_id [$];
  int                 pend_cyc [$];
  pop_resp_t          resp_exp;
  logic [count_w-1:0] rcv_count;
  int                 sender_credits;
  int                 pulses;
  int                 cyc;
  int                 seed;
  int                 n_checks;
  int                 n_errors;
  string              test_name;

  always #2 clk = ~clk;

  shared_fifo_top #(
    .num_fifos(num_fifos),
    .depth(depth)
  ) uut (
    .clk,
    .rst_n,
    .push_sender_in_reset,
    .push_receiver_in_reset,
    .push_credit_stall,
    .push_credit,
    .push_valid,
    .push_req,
    .push_full,
    .credit_initial,
    .credit_withhold,
    .credit_available,
    .credit_count,
    .pop,
    .pop_fifo_id,
    .pop_resp,
    .fifo_empty
  );

  task automatic check_resp(input string what, input pop_resp_t exp, input pop_resp_t act);
    n_checks++;
    if (exp.valid !== act.valid ||
        (exp.valid && (exp.fifo_id !== act.fifo_id || exp.data !== act.data))) begin
      n_errors++;
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [count_w-1:0] exp,
                             input logic [count_w-1:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch in %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_empty(input string what, input logic [num_fifos-1:0] exp,
                             input logic [num_fifos-1:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic apply_reset(input logic [count_w-1:0] init_credits,
                             input logic [count_w-1:0] withhold);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    push_valid = 1'b0;
    pop = 1'b0;
    push_credit_stall = 1'b0;
    credit_initial = init_credits;
    credit_withhold = withhold;
    repeat (10) @(posedge clk);
    #1;
    check_flag("receiver in reset", 1'b1, push_receiver_in_reset);
    rst_n = 1'b1;
    rcv_count = init_credits;
    sender_credits = 0;
    pulses = 0;
    for (int f = 0; f < num_fifos; f++) begin
      q[f].delete();
      vis_cnt[f] = 0;
    end
    pend_id.delete();
    pend_cyc.delete();
    resp_exp = '0;
    // Staging entry not ready yet, so no credit in this cycle
    @(negedge clk);
    check_flag("credit hold-off", 1'b0, push_credit);
    check_flag("receiver out of reset", 1'b0, push_receiver_in_reset);
    check_empty("fifo_empty after reset", '1, fifo_empty);
    check_resp("pop_resp after reset", '0, pop_resp);
  endtask

  // Drives one cycle and checks and updates the model at the falling edge
  task automatic step(input logic do_push, input push_req_t req, input logic do_pop,
                      input logic [fifo_id_w-1:0] pid, input logic stall,
                      input logic [count_w-1:0] withhold);
    logic [num_fifos-1:0] exp_empty;
    logic                 pulse_exp;
    logic [count_w-1:0]   avail_exp;
    @(posedge clk);
    #1;
    cyc++;
    push_valid = do_push;
    push_req = req;
    pop = do_pop;
    pop_fifo_id = pid;
    push_credit_stall = stall;
    credit_withhold = withhold;
    if (do_push) begin
      sender_credits--;
    end
    @(negedge clk);
    // Pushes show up two cycles after they were driven
    while (pend_cyc.size() > 0 && pend_cyc[0] + 2 <= cyc) begin
      vis_cnt[pend_id[0]]++;
      pend_id.delete(0);
      pend_cyc.delete(0);
    end
    for (int f = 0; f < num_fifos; f++) begin
      exp_empty[f] = vis_cnt[f] == 0;
    end
    pulse_exp = !stall && (rcv_count > withhold);
    avail_exp = (rcv_count > withhold) ? rcv_count - withhold : '0;
    check_empty("fifo_empty", exp_empty, fifo_empty);
    check_resp("pop_resp", resp_exp, pop_resp);
    check_flag("push_credit", pulse_exp, push_credit);
    check_count("credit_count", rcv_count, credit_count);
    check_count("credit_available", avail_exp, credit_available);
    if (push_credit) begin
      sender_credits++;
      pulses++;
    end
    // A response this cycle frees an entry and returns its credit
    rcv_count = rcv_count + count_w'(resp_exp.valid) - count_w'(pulse_exp);
    resp_exp = '0;
    if (do_pop && vis_cnt[pid] > 0) begin
      resp_exp.valid = 1'b1;
      resp_exp.fifo_id = pid;
      resp_exp.data = q[pid].pop_front();
      vis_cnt[pid]--;
    end
    if (do_push) begin
      q[req.fifo_id].push_back(req.data);
      pend_id.push_back(int'(req.fifo_id));
      pend_cyc.push_back(cyc);
    end
  endtask

  task automatic idle_steps(input int n, input logic [count_w-1:0] withhold);
    for (int i = 0; i < n; i++) begin
      step(1'b0, '0, 1'b0, '0, 1'b0, withhold);
    end
  endtask

  task automatic drain_all();
    int   pick;
    logic busy;
    busy = 1'b1;
    while (busy) begin
      busy = 1'b0;
      pick = -1;
      for (int f = 0; f < num_fifos; f++) begin
        if (q[f].size() > 0) begin
          busy = 1'b1;
        end
        if (vis_cnt[f] > 0 && pick < 0) begin
          pick = f;
        end
      end
      if (busy) begin
        step(1'b0, '0, pick >= 0, fifo_id_w'((pick >= 0) ? pick : 0), 1'b0, '0);
      end
    end
    idle_steps(20, '0);
  endtask

  initial begin
    #((test_cycles + 200) * 4);
    $display("Timeout: the test did not reach its end in time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    push_req_t            req;
    logic                 do_push;
    logic                 do_pop;
    logic [fifo_id_w-1:0] pid;
    logic                 stall;
    seed = 32'h5738;
    n_checks = 0;
    n_errors = 0;
    cyc = 0;
    rst_n = 1'b0;
    push_sender_in_reset = 1'b0;
    push_credit_stall = 1'b0;
    push_valid = 1'b0;
    push_req = '0;
    credit_initial = count_w'(depth);
    credit_withhold = '0;
    pop = 1'b0;
    pop_fifo_id = '0;

    test_name = "initial credits";
    apply_reset(count_w'(depth), '0);
    idle_steps(30, '0);
    check_count("credit pulses", count_w'(depth), count_w'(pulses));
    check_count("credit_count after release", '0, credit_count);

    test_name = "withhold and stall";
    apply_reset(count_w'(depth), 5'd5);
    for (int i = 0; i < 40; i++) begin
      stall = ($random(seed) & 3) == 0;
      step(1'b0, '0, 1'b0, '0, stall, 5'd5);
    end
    check_count("pulses under withhold", count_w'(depth - 5), count_w'(pulses));
    idle_steps(20, '0);
    check_count("pulses after withhold", count_w'(depth), count_w'(pulses));

    test_name = "random traffic";
    for (int i = 0; i < n_traffic; i++) begin
      req.fifo_id = fifo_id_w'($random(seed));
      req.data = data_w'($random(seed));
      do_push = (sender_credits > 0) && (($random(seed) & 1) != 0);
      do_pop = ($random(seed) & 7) < 3;
      pid = fifo_id_w'($random(seed));
      stall = ($random(seed) & 7) == 0;
      step(do_push, req, do_pop, pid, stall, '0);
    end
    test_name = "drain after traffic";
    drain_all();
    check_count("credit conservation", count_w'(depth),
                count_w'(sender_credits) + credit_count);
    check_flag("push_full after drain", 1'b0, push_full);

    // Fill every entry with no pops in between
    test_name = "full flag";
    for (int i = 0; i < depth; i++) begin
      req.fifo_id = fifo_id_w'($random(seed));
      req.data = data_w'($random(seed));
      step(sender_credits > 0, req, 1'b0, '0, 1'b0, '0);
    end
    idle_steps(4, '0);
    check_flag("push_full", 1'b1, push_full);
    drain_all();
    check_count("credit conservation", count_w'(depth),
                count_w'(sender_credits) + credit_count);

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- src.f
fifo_shared_pkg.sv
data_ram.sv
credit_receiver.sv
freelist_alloc.sv
shared_fifo_push_ctrl_credit.sv
linked_list_ctrl.sv
pop_ctrl.sv
shared_fifo_top.sv
tb_shared_fifo.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_shared_fifo -f src.f \
  -o sim_shared_fifo > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_shared_fifo > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0
